// ==== video_config.svh ====
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// component width, same for rgb and ycbcr
`define VID_DW 8

// frame geometry, line length must be even for 4:2:0
`define VID_X_SIZE 16
`define VID_Y_SIZE 8

// counter widths
`define VID_XW $clog2(`VID_X_SIZE)
`define VID_YW $clog2(`VID_Y_SIZE)

`endif

// ==== video_pkg.sv ====
package video_pkg;

    `include "video_config.svh"

    typedef struct packed {
        logic [`VID_DW-1:0] r;
        logic [`VID_DW-1:0] g;
        logic [`VID_DW-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [`VID_DW-1:0] y;
        logic [`VID_DW-1:0] cb;
        logic [`VID_DW-1:0] cr;
    } ycc_t;

    // eof only on the last pixel, which also has eol
    typedef struct packed {
        rgb_t pix;
        logic eol;
        logic eof;
    } rgb_beat_t;

    typedef struct packed {
        ycc_t pix;
        logic eol;
        logic eof;
    } ycc_beat_t;

    // chroma fields are meaningful only with their valid bits
    typedef struct packed {
        ycc_t               pix;
        logic               y_valid;
        logic               cb_valid;
        logic               cr_valid;
        logic               eof;
        logic [`VID_XW-1:0] x;  // pixel position in line
        logic [`VID_YW-1:0] y;  // line position in frame
    } sub_beat_t;

endpackage

// ==== rgb_to_ycbcr.sv ====
`include "video_config.svh"
`timescale 1ns/1ns

module rgb_to_ycbcr (
    input  logic                  clk,
    input  logic                  resetn,
    input  video_pkg::rgb_beat_t  in_beat_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    output video_pkg::ycc_beat_t  out_beat_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i
);

    localparam int PW = `VID_DW + 10;           // product width, signed
    localparam int SW = PW + 2;                 // sum width, signed
    localparam int MAX_PIX = (1 << `VID_DW) - 1;

    logic signed [PW-1:0] r_s, g_s, b_s;
    logic signed [PW-1:0] prod_q [9];   // y r/g/b, cb r/g/b, cr r/g/b
    logic                 s1_valid;
    logic                 s1_eol, s1_eof;
    logic                 s1_ready, s2_ready;
    logic signed [SW-1:0] y_sum, cb_sum, cr_sum;
    logic signed [SW-1:0] cb_off, cr_off;

    function automatic logic [`VID_DW-1:0] clamp_pix(input logic signed [SW-1:0] v);
        if (v < 0)
            return '0;
        else if (v > MAX_PIX)
            return '1;
        else
            return v[`VID_DW-1:0];
    endfunction

    // each stage moves when the next one is empty or draining
    assign s2_ready   = !out_valid_o || out_ready_i;
    assign s1_ready   = !s1_valid || s2_ready;
    assign in_ready_o = s1_ready;

    always_comb begin
        r_s = PW'(in_beat_i.pix.r); // zero extend, always positive
        g_s = PW'(in_beat_i.pix.g);
        b_s = PW'(in_beat_i.pix.b);
    end

    // stage 1: weighted products
    always_ff @(posedge clk) begin
        if (in_valid_i && s1_ready) begin
            prod_q[0] <= 77 * r_s;
            prod_q[1] <= 150 * g_s;
            prod_q[2] <= 29 * b_s;
            prod_q[3] <= -43 * r_s;
            prod_q[4] <= -85 * g_s;
            prod_q[5] <= 128 * b_s;
            prod_q[6] <= 128 * r_s;
            prod_q[7] <= -107 * g_s;
            prod_q[8] <= -21 * b_s;
            s1_eol    <= in_beat_i.eol;
            s1_eof    <= in_beat_i.eof;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            s1_valid <= 1'b0;
        else if (s1_ready)
            s1_valid <= in_valid_i;
    end

    // stage 2: sums with rounding, chroma offset after the shift
    always_comb begin
        y_sum  = prod_q[0] + prod_q[1] + prod_q[2] + 128;
        cb_sum = prod_q[3] + prod_q[4] + prod_q[5] + 128;
        cr_sum = prod_q[6] + prod_q[7] + prod_q[8] + 128;
        cb_off = (cb_sum >>> 8) + 128;
        cr_off = (cr_sum >>> 8) + 128;
    end

    always_ff @(posedge clk) begin
        if (s1_valid && s2_ready) begin
            out_beat_o.pix.y  <= clamp_pix(y_sum >>> 8);
            out_beat_o.pix.cb <= clamp_pix(cb_off);  // can reach 256
            out_beat_o.pix.cr <= clamp_pix(cr_off);
            out_beat_o.eol    <= s1_eol;
            out_beat_o.eof    <= s1_eof;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            out_valid_o <= 1'b0;
        else if (s2_ready)
            out_valid_o <= s1_valid;
    end

    a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
        else $error("converter output changed while stalled");

endmodule

// ==== chroma_line_ram.sv ====
`include "video_config.svh"
`timescale 1ns/1ns

module chroma_line_ram #(
    parameter int DEPTH = `VID_X_SIZE / 2,
    parameter int WIDTH = 2 * (`VID_DW + 1)
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  logic [WIDTH-1:0]         wr_data_i,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    input  logic                     rd_en_i,
    output logic [WIDTH-1:0]         rd_data_o
);

    logic [WIDTH-1:0] mem [DEPTH];  // one entry per 2-pixel pair

    always_ff @(posedge clk) begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    // read data held until the next read enable
    always_ff @(posedge clk) begin
        if (rd_en_i)
            rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== chroma_subsample_420.sv ====
`include "video_config.svh"
`timescale 1ns/1ns

module chroma_subsample_420 #(
    parameter int X_SIZE = `VID_X_SIZE,
    parameter int Y_SIZE = `VID_Y_SIZE
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  video_pkg::ycc_beat_t  in_beat_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    output video_pkg::sub_beat_t  out_beat_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i
);

    localparam int LW = `VID_DW + 1;      // pair sum width
    localparam int QW = `VID_DW + 2;      // four-sum plus rounding
    localparam int DEPTH = X_SIZE / 2;
    localparam int AW = $clog2(DEPTH);

    logic [`VID_XW-1:0] pix_cnt;
    logic [`VID_YW-1:0] line_cnt;
    logic               in_fire;
    logic               x_odd, y_odd;
    logic               quad_end;
    logic [`VID_DW-1:0] cb_hold_q, cr_hold_q;
    logic [LW-1:0]      cb_pair, cr_pair;
    logic [LW-1:0]      cb_above, cr_above;
    logic [QW-1:0]      cb_quad, cr_quad;
    logic [`VID_DW-1:0] cb_avg, cr_avg;
    logic [AW-1:0]      lb_addr;
    logic               lb_we, lb_re;

    // single register slice
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign in_fire    = in_valid_i && in_ready_o;

    assign x_odd    = pix_cnt[0];
    assign y_odd    = line_cnt[0];
    assign quad_end = x_odd && y_odd;  // bottom right of a 2x2 block

    // line buffer control
    assign lb_addr = AW'(pix_cnt >> 1);
    assign lb_we   = in_fire && x_odd && !y_odd;
    assign lb_re   = in_fire && !x_odd && y_odd;  // data ready by the odd pixel

    always_comb begin
        cb_pair = LW'(cb_hold_q) + LW'(in_beat_i.pix.cb);
        cr_pair = LW'(cr_hold_q) + LW'(in_beat_i.pix.cr);
        cb_quad = QW'(cb_pair) + QW'(cb_above) + QW'(2);
        cr_quad = QW'(cr_pair) + QW'(cr_above) + QW'(2);
        cb_avg  = cb_quad[QW-1:2];  // divide by four
        cr_avg  = cr_quad[QW-1:2];
    end

    chroma_line_ram #(
        .DEPTH (DEPTH),
        .WIDTH (2 * LW)
    ) u_line_ram (
        .clk       (clk),
        .wr_addr_i (lb_addr),
        .wr_data_i ({cb_pair, cr_pair}),
        .wr_en_i   (lb_we),
        .rd_addr_i (lb_addr),
        .rd_en_i   (lb_re),
        .rd_data_o ({cb_above, cr_above})
    );

    // position counters
    always_ff @(posedge clk) begin
        if (!resetn) begin
            pix_cnt  <= '0;
            line_cnt <= '0;
        end else if (in_fire) begin
            if (in_beat_i.eof) begin
                pix_cnt  <= '0;
                line_cnt <= '0;
            end else if (in_beat_i.eol) begin
                pix_cnt  <= '0;
                line_cnt <= (line_cnt == Y_SIZE - 1) ? '0 : line_cnt + 1'b1;
            end else begin
                pix_cnt <= pix_cnt + 1'b1;
            end
        end
    end

    // even pixel chroma on both line parities
    always_ff @(posedge clk) begin
        if (in_fire && !x_odd) begin
            cb_hold_q <= in_beat_i.pix.cb;
            cr_hold_q <= in_beat_i.pix.cr;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            out_beat_o.pix.y    <= in_beat_i.pix.y;
            out_beat_o.pix.cb   <= quad_end ? cb_avg : in_beat_i.pix.cb;
            out_beat_o.pix.cr   <= quad_end ? cr_avg : in_beat_i.pix.cr;
            out_beat_o.y_valid  <= 1'b1;    // luma on every pixel
            out_beat_o.cb_valid <= quad_end;
            out_beat_o.cr_valid <= quad_end;
            out_beat_o.eof      <= in_beat_i.eof;
            out_beat_o.x        <= pix_cnt;
            out_beat_o.y        <= line_cnt;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn)
            out_valid_o <= 1'b0;
        else if (in_ready_o)
            out_valid_o <= in_valid_i;
    end

    // eol from upstream must arrive before the line overruns
    a_pix_range: assert property (@(posedge clk) disable iff (!resetn)
        in_fire && (pix_cnt == X_SIZE - 1) |-> in_beat_i.eol)
        else $error("pixel counter ran past the line length");

    a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_beat_o))
        else $error("subsampler output changed while stalled");

endmodule

// ==== color_subsample_top.sv ====
`timescale 1ns/1ns

module color_subsample_top (
    input  logic                  clk,
    input  logic                  resetn,
    input  video_pkg::rgb_beat_t  in_beat_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    output video_pkg::sub_beat_t  out_beat_o,
    output logic                  out_valid_o,
    input  logic                  out_ready_i
);

    // converter to subsampler link
    video_pkg::ycc_beat_t ycc_beat;
    logic                 ycc_valid;
    logic                 ycc_ready;

    // 2 cycle colour conversion
    rgb_to_ycbcr u_csc (
        .clk         (clk),
        .resetn      (resetn),
        .in_beat_i   (in_beat_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_beat_o  (ycc_beat),
        .out_valid_o (ycc_valid),
        .out_ready_i (ycc_ready)
    );

    chroma_subsample_420 u_sub (
        .clk         (clk),
        .resetn      (resetn),
        .in_beat_i   (ycc_beat),
        .in_valid_i  (ycc_valid),
        .in_ready_o  (ycc_ready),
        .out_beat_o  (out_beat_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

endmodule

// ==== tb_color_subsample.sv ====
`include "video_config.svh"
`timescale 1ns/1ns

module tb_color_subsample;

    localparam int FRAME2_LINES  = 4;       // short frame right after the full one
    localparam int TOTAL_BEATS   = `VID_X_SIZE * (`VID_Y_SIZE + FRAME2_LINES);
    localparam int SEND_TIMEOUT  = 20000;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                 clk;
    logic                 resetn;
    video_pkg::rgb_beat_t in_beat_i;
    logic                 in_valid_i;
    logic                 in_ready_o;
    video_pkg::sub_beat_t out_beat_o;
    logic                 out_valid_o;
    logic                 out_ready_i;

    logic [31:0]          lfsr_state = 32'hb50f8e3a;
    video_pkg::rgb_t      frame_rgb [`VID_Y_SIZE][`VID_X_SIZE];
    video_pkg::rgb_beat_t in_q [$];
    video_pkg::sub_beat_t exp_q [$];
    int                   out_count = 0;

    color_subsample_top DUT (
        .clk         (clk),
        .resetn      (resetn),
        .in_beat_i   (in_beat_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_beat_o  (out_beat_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = next_lfsr(lfsr_state);
        end
    endtask

    function automatic logic [7:0] saturate(input int v);
        if (v < 0)
            return 8'd0;
        if (v > 255)
            return 8'd255;
        return v[7:0];
    endfunction

    // full-range bt.601 with arithmetic >>> on int
    function automatic video_pkg::ycc_t convert_pixel(input video_pkg::rgb_t p);
        int r, g, b;
        video_pkg::ycc_t c;
        r = p.r;
        g = p.g;
        b = p.b;
        c.y  = saturate((77 * r + 150 * g + 29 * b + 128) >>> 8);
        c.cb = saturate(((-43 * r - 85 * g + 128 * b + 128) >>> 8) + 128);
        c.cr = saturate(((128 * r - 107 * g - 21 * b + 128) >>> 8) + 128);
        return c;
    endfunction

    // expected output for pixel (x, y) of the frame held in frame_rgb
    function automatic video_pkg::sub_beat_t reference_beat(input int x, input int y,
                                                            input int lines);
        video_pkg::sub_beat_t e;
        video_pkg::ycc_t      c;
        video_pkg::ycc_t      p;
        int                   cb_sum, cr_sum;
        int                   dx, dy;
        c = convert_pixel(frame_rgb[y][x]);
        e = '0;
        e.pix.y   = c.y;
        e.y_valid = 1'b1;
        e.eof     = (x == `VID_X_SIZE - 1) && (y == lines - 1);
        e.x       = x[`VID_XW-1:0];
        e.y       = y[`VID_YW-1:0];
        if ((x % 2 == 1) && (y % 2 == 1)) begin
            cb_sum = 2;     // rounding
            cr_sum = 2;
            for (dy = 0; dy < 2; dy++) begin
                for (dx = 0; dx < 2; dx++) begin
                    p = convert_pixel(frame_rgb[y - dy][x - dx]);
                    cb_sum += p.cb;
                    cr_sum += p.cr;
                end
            end
            e.pix.cb   = cb_sum >> 2;
            e.pix.cr   = cr_sum >> 2;
            e.cb_valid = 1'b1;
            e.cr_valid = 1'b1;
        end
        return e;
    endfunction

    // random frame into the input queue and its expected beats into exp_q
    task automatic build_frame(input int lines);
        video_pkg::rgb_beat_t b;
        logic [31:0]          v;
        int                   x, y;
        for (y = 0; y < lines; y++) begin
            for (x = 0; x < `VID_X_SIZE; x++) begin
                random_bits(24, v);
                frame_rgb[y][x] = v[23:0];
                b.pix = v[23:0];
                b.eol = (x == `VID_X_SIZE - 1);
                b.eof = b.eol && (y == lines - 1);
                in_q.push_back(b);
            end
        end
        for (y = 0; y < lines; y++)
            for (x = 0; x < `VID_X_SIZE; x++)
                exp_q.push_back(reference_beat(x, y, lines));
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s at output beat %0d: got 0x%0h, expected 0x%0h",
                     name, out_count, got, exp);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // checks every transferred output beat against the reference queue
    always @(posedge clk) begin : compare_outputs
        video_pkg::sub_beat_t exp_beat;
        if (resetn && out_valid_o && out_ready_i) begin
            if (exp_q.size() == 0) begin
                abort_run("an output beat arrived with no expected beat left");
            end else begin
                exp_beat = exp_q.pop_front();
                check_value("out_beat_o.y_valid", out_beat_o.y_valid, exp_beat.y_valid);
                check_value("out_beat_o.pix.y", out_beat_o.pix.y, exp_beat.pix.y);
                check_value("out_beat_o.x", out_beat_o.x, exp_beat.x);
                check_value("out_beat_o.y", out_beat_o.y, exp_beat.y);
                check_value("out_beat_o.eof", out_beat_o.eof, exp_beat.eof);
                check_value("out_beat_o.cb_valid", out_beat_o.cb_valid, exp_beat.cb_valid);
                check_value("out_beat_o.cr_valid", out_beat_o.cr_valid, exp_beat.cr_valid);
                if (exp_beat.cb_valid) begin    // chroma only meaningful here
                    check_value("out_beat_o.pix.cb", out_beat_o.pix.cb, exp_beat.pix.cb);
                    check_value("out_beat_o.pix.cr", out_beat_o.pix.cr, exp_beat.pix.cr);
                end
                out_count++;
            end
        end
    end

    initial begin : main_sequence
        int          cycles;
        logic [31:0] bits;
        logic        accepted;
        resetn      = 1'b0;
        in_valid_i  = 1'b0;
        in_beat_i   = '0;
        out_ready_i = 1'b0;

        build_frame(`VID_Y_SIZE);
        build_frame(FRAME2_LINES);  // follows the first frame with no break

        repeat (5) begin
            @(negedge clk);
            check_value("out_valid_o", out_valid_o, 1'b0);
        end
        resetn = 1'b1;
        @(negedge clk);
        check_value("out_valid_o", out_valid_o, 1'b0);
        check_value("in_ready_o", in_ready_o, 1'b1);

        // send both frames with random gaps and random back-pressure
        cycles   = 0;
        accepted = 1'b0;
        while (in_q.size() > 0 || in_valid_i) begin
            @(negedge clk);
            if (accepted)
                in_valid_i = 1'b0;
            random_bits(2, bits);
            out_ready_i = (bits[1:0] != 2'b00);     // ready 3 of 4 cycles
            if (!in_valid_i && in_q.size() > 0) begin
                random_bits(2, bits);
                if (bits[1:0] != 2'b00) begin
                    in_beat_i  = in_q.pop_front();
                    in_valid_i = 1'b1;
                end
            end
            @(posedge clk);
            accepted = in_valid_i && in_ready_o;
            cycles++;
            if (cycles > SEND_TIMEOUT)
                abort_run("the DUT did not accept all input pixels in time");
        end

        cycles = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            random_bits(2, bits);
            out_ready_i = (bits[1:0] != 2'b00);
            cycles++;
            if (cycles > DRAIN_TIMEOUT)
                abort_run("the DUT did not deliver all output beats in time");
        end

        // nothing extra may come out
        @(negedge clk);
        out_ready_i = 1'b1;
        repeat (8) @(negedge clk);
        check_value("out_valid_o", out_valid_o, 1'b0);

        $display("No errors");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+.
video_pkg.sv
rgb_to_ycbcr.sv
chroma_line_ram.sv
chroma_subsample_420.sv
color_subsample_top.sv
tb_color_subsample.sv
